/* design/fifo_command_reader.sv */
// Host-to-FPGA FIFO read state machine and command word latch

`timescale 1ns/1ns

module fifo_command_reader import scara_link_pkg::*; (
	input  logic          CLOCK_50,
	input  logic          arst_n,
	input  logic [31:0]   h2f_fill_level,
	input  command_word_t h2f_readdata,
	input  logic          arm_idle,
	input  logic          echo_busy,
	output logic          h2f_read,
	output logic          cmd_valid,
	output command_word_t cmd_word
);

	// ========================================
	// Read machine states
	// ========================================

	// AWAIT   wait for data, idle arm and no echo pending
	// READ    read strobe is on the FIFO for this cycle
	// DELAY   popped word now sits on readdata
	// LATCH   word held, cmd_valid strobe out
	typedef enum logic [1:0] {
		ST_AWAIT,
		ST_READ,
		ST_DELAY,
		ST_LATCH
	} read_state_t;

	read_state_t state_q;

	// Go condition for a new read
	logic fifo_has_data;
	logic read_go;

	assign fifo_has_data = (h2f_fill_level != 32'd0);

	// One command in flight at a time
	// Arm must be done moving and the last echo written
	assign read_go = fifo_has_data && arm_idle && !echo_busy;

	// ========================================
	// Control path
	// ========================================

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state_q   <= ST_AWAIT;
			h2f_read  <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			case (state_q)
				ST_AWAIT: begin
					cmd_valid <= 1'b0;
					if (read_go) begin
						// Strobe shows up next cycle, exactly one pop
						h2f_read <= 1'b1;
						state_q  <= ST_READ;
					end
				end
				ST_READ: begin
					// Drop the strobe before the data appears
					h2f_read <= 1'b0;
					state_q  <= ST_DELAY;
				end
				ST_DELAY: begin
					// Data is stable on readdata now
					cmd_valid <= 1'b1;
					state_q   <= ST_LATCH;
				end
				ST_LATCH: begin
					cmd_valid <= 1'b0;
					state_q   <= ST_AWAIT;
				end
				default: begin
					h2f_read  <= 1'b0;
					cmd_valid <= 1'b0;
					state_q   <= ST_AWAIT;
				end
			endcase
		end
	end

	// ========================================
	// Word latch
	// ========================================

	// Capture lines up with the cmd_valid strobe
	always_ff @(posedge CLOCK_50) begin
		if (state_q == ST_DELAY) begin
			cmd_word <= h2f_readdata;
		end
	end

endmodule

/* design/fifo_echo_writer.sv */
// FPGA-to-HPS FIFO write state machine echoing each accepted command word

`timescale 1ns/1ns

module fifo_echo_writer import scara_link_pkg::*; (
	input  logic          CLOCK_50,
	input  logic          arst_n,
	input  logic          cmd_valid,
	input  command_word_t cmd_word,
	input  logic          f2h_full,
	output logic          f2h_write,
	output logic [31:0]   f2h_writedata,
	output logic          echo_busy
);

	// IDLE  nothing to send
	// HOLD  word pending, waiting on FIFO space
	// DONE  one cycle after the write, lets the reader see it land
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_HOLD,
		WR_DONE
	} write_state_t;

	write_state_t state_q;

	// Write goes out in the first free cycle
	assign f2h_write = (state_q == WR_HOLD) && !f2h_full;

	// Busy from the strobe itself, so the reader never sees a gap
	assign echo_busy = cmd_valid || (state_q != WR_IDLE);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= WR_IDLE;
		end else begin
			case (state_q)
				WR_IDLE: begin
					if (cmd_valid) begin
						state_q <= WR_HOLD;
					end
				end
				WR_HOLD: begin
					// Stay here as long as the host side is full
					if (!f2h_full) begin
						state_q <= WR_DONE;
					end
				end
				WR_DONE: begin
					state_q <= WR_IDLE;
				end
				default: begin
					state_q <= WR_IDLE;
				end
			endcase
		end
	end

	// Raw word held for the echo
	always_ff @(posedge CLOCK_50) begin
		if (cmd_valid) begin
			f2h_writedata <= cmd_word.raw;
		end
	end

endmodule

/* design/hex_display.sv */
// Six active-low seven-segment digit decoders and accepted command counter

`timescale 1ns/1ns

module hex_display (
	input  logic       CLOCK_50,
	input  logic       arst_n,
	input  logic       cmd_valid,
	input  logic [7:0] steps1,
	input  logic [7:0] steps2,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	// Commands accepted since reset, wraps at 256
	logic [7:0] cmd_count;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			cmd_count <= 8'd0;
		end else if (cmd_valid) begin
			cmd_count <= cmd_count + 8'd1;
		end
	end

	// ========================================
	// Segment table
	// ========================================

	// Segment a in bit 0, g in bit 6
	// Low level lights a segment
	function automatic logic [6:0] seg7(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'hA: seg7 = 7'b0001000;
			4'hB: seg7 = 7'b0000011;
			4'hC: seg7 = 7'b1000110;
			4'hD: seg7 = 7'b0100001;
			4'hE: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	// Joint 1 steps on the right pair
	assign hex0 = seg7(steps1[3:0]);
	assign hex1 = seg7(steps1[7:4]);
	// Joint 2 steps in the middle
	assign hex2 = seg7(steps2[3:0]);
	assign hex3 = seg7(steps2[7:4]);
	// Command count on the left
	assign hex4 = seg7(cmd_count[3:0]);
	assign hex5 = seg7(cmd_count[7:4]);

endmodule

/* design/scara_link_pkg.sv */
// Command word union, command codes and step timing constants for the arm link

package scara_link_pkg;

	// ========================================
	// Command word layout
	// ========================================

	// Field view of one host word
	// y in the top 14 bits, x below it, command nibble at the bottom
	typedef struct packed {
		logic [13:0] y_value;
		logic [13:0] x_value;
		logic [3:0]  cmd;
	} command_fields_t;

	// Same 32 bits seen two ways
	// Raw view goes back to the host untouched as the echo
	typedef union packed {
		logic [31:0]     raw;
		command_fields_t fields;
	} command_word_t;

	// ========================================
	// Command codes
	// ========================================

	// Move both joints, x to joint 1 and y to joint 2
	localparam logic [3:0] CMD_MOVE = 4'd1;

	// ========================================
	// Step argument and timing
	// ========================================

	// Low bits of an argument hold the step count
	localparam int STEP_COUNT_W = 8;

	// Direction flag sits just above the count
	localparam int STEP_DIR_BIT = 8;

	// Clock cycles per step pulse
	// Pulse is high for the first half of the period
	localparam int STEP_PERIOD_SLOW = 32;
	localparam int STEP_PERIOD_FAST = 8;

	// Period counter width, sized for the slow rate
	localparam int STEP_PHASE_W = $clog2(STEP_PERIOD_SLOW);

endpackage

/* design/scara_link_top.sv */
// Top level linking FIFO reader, echo writer, two joint drivers and hex display

`timescale 1ns/1ns

module scara_link_top import scara_link_pkg::*; (
	input  logic          CLOCK_50,
	input  logic          arst_n,
	input  logic [31:0]   h2f_fill_level,
	input  command_word_t h2f_readdata,
	input  logic          f2h_full,
	input  logic          fast,
	output logic          h2f_read,
	output logic          f2h_write,
	output logic [31:0]   f2h_writedata,
	output logic          step1,
	output logic          dir1,
	output logic          step2,
	output logic          dir2,
	output logic [6:0]    hex0,
	output logic [6:0]    hex1,
	output logic [6:0]    hex2,
	output logic [6:0]    hex3,
	output logic [6:0]    hex4,
	output logic [6:0]    hex5
);

	// ========================================
	// Internal nets
	// ========================================

	command_word_t           cmd_word;
	logic                    cmd_valid;
	logic                    echo_busy;
	logic                    move_start;
	logic                    arm_idle;
	logic                    finished1;
	logic                    finished2;
	logic [STEP_COUNT_W-1:0] steps1;
	logic [STEP_COUNT_W-1:0] steps2;

	// Only move commands start the joints
	assign move_start = cmd_valid && (cmd_word.fields.cmd == CMD_MOVE);

	// Both joints parked
	assign arm_idle = finished1 && finished2;

	// ========================================
	// FIFO side
	// ========================================

	fifo_command_reader reader_i (
		.CLOCK_50       (CLOCK_50),
		.arst_n         (arst_n),
		.h2f_fill_level (h2f_fill_level),
		.h2f_readdata   (h2f_readdata),
		.arm_idle       (arm_idle),
		.echo_busy      (echo_busy),
		.h2f_read       (h2f_read),
		.cmd_valid      (cmd_valid),
		.cmd_word       (cmd_word)
	);

	fifo_echo_writer writer_i (
		.CLOCK_50      (CLOCK_50),
		.arst_n        (arst_n),
		.cmd_valid     (cmd_valid),
		.cmd_word      (cmd_word),
		.f2h_full      (f2h_full),
		.f2h_write     (f2h_write),
		.f2h_writedata (f2h_writedata),
		.echo_busy     (echo_busy)
	);

	// ========================================
	// Joints and display
	// ========================================

	// x argument drives joint 1
	stepper_joint joint1_i (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.start      (move_start),
		.step_arg   (cmd_word.fields.x_value),
		.fast       (fast),
		.step       (step1),
		.dir        (dir1),
		.finished   (finished1),
		.steps_done (steps1)
	);

	// y argument drives joint 2
	stepper_joint joint2_i (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.start      (move_start),
		.step_arg   (cmd_word.fields.y_value),
		.fast       (fast),
		.step       (step2),
		.dir        (dir2),
		.finished   (finished2),
		.steps_done (steps2)
	);

	hex_display display_i (
		.CLOCK_50  (CLOCK_50),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.steps1    (steps1),
		.steps2    (steps2),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

endmodule

/* design/stepper_joint.sv */
// Step pulse generator for one arm joint with step counter

`timescale 1ns/1ns

module stepper_joint import scara_link_pkg::*; (
	input  logic                    CLOCK_50,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic [13:0]             step_arg,
	input  logic                    fast,
	output logic                    step,
	output logic                    dir,
	output logic                    finished,
	output logic [STEP_COUNT_W-1:0] steps_done
);

	// ========================================
	// Move state
	// ========================================

	// Steps still to emit, current one included
	logic [STEP_COUNT_W-1:0] remaining_q;

	// Position inside the current step period
	logic [STEP_PHASE_W-1:0] phase_q;

	// Pulses running
	logic busy_q;

	// Rate held for the whole move
	logic fast_q;

	// Count from the argument
	logic [STEP_COUNT_W-1:0] load_count;

	// Period end and high-time limit for the held rate
	logic [STEP_PHASE_W-1:0] phase_last;
	logic [STEP_PHASE_W-1:0] phase_half;

	assign load_count = step_arg[STEP_COUNT_W-1:0];

	assign phase_last = fast_q ? STEP_PHASE_W'(STEP_PERIOD_FAST - 1)
	                           : STEP_PHASE_W'(STEP_PERIOD_SLOW - 1);
	assign phase_half = fast_q ? STEP_PHASE_W'(STEP_PERIOD_FAST / 2)
	                           : STEP_PHASE_W'(STEP_PERIOD_SLOW / 2);

	// ========================================
	// Outputs
	// ========================================

	// High for the first half of each period
	assign step = busy_q && (phase_q < phase_half);

	// Idle joint reports finished
	assign finished = !busy_q;

	// ========================================
	// Pulse sequencer
	// ========================================

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			busy_q      <= 1'b0;
			fast_q      <= 1'b0;
			dir         <= 1'b0;
			remaining_q <= '0;
			phase_q     <= '0;
			steps_done  <= '0;
		end else if (start) begin
			// New move replaces the previous total
			dir         <= step_arg[STEP_DIR_BIT];
			fast_q      <= fast;
			remaining_q <= load_count;
			phase_q     <= '0;
			steps_done  <= '0;
			// Zero count means no pulse at all
			busy_q      <= (load_count != '0);
		end else if (busy_q) begin
			if (phase_q == phase_last) begin
				// End of one full step period
				phase_q     <= '0;
				steps_done  <= steps_done + 1'b1;
				remaining_q <= remaining_q - 1'b1;
				if (remaining_q == STEP_COUNT_W'(1)) begin
					busy_q <= 1'b0;
				end
			end else begin
				phase_q <= phase_q + 1'b1;
			end
		end
	end

endmodule

/* sim/scara_link_assert.sv */
// Concurrent assertions on the FIFO strobes and joint step outputs, bound to the top level

`timescale 1ns/1ns

module scara_link_assert (
	input logic CLOCK_50,
	input logic arst_n,
	input logic h2f_read,
	input logic f2h_write,
	input logic f2h_full,
	input logic step1,
	input logic step2
);

	// Running total of assertion failures
	int unsigned fail_count = 0;

	// Strobes last exactly one cycle
	read_single_pulse: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		h2f_read |=> !h2f_read)
		else begin
			$error("h2f_read stayed high for more than one cycle");
			fail_count++;
		end

	write_single_pulse: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		f2h_write |=> !f2h_write)
		else begin
			$error("f2h_write stayed high for more than one cycle");
			fail_count++;
		end

	// Arm is parked whenever a new word is read
	read_when_parked: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		h2f_read |-> !step1 && !step2)
		else begin
			$error("h2f_read issued while a step output was active");
			fail_count++;
		end

	// Never push into a full FIFO
	write_not_full: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		f2h_write |-> !f2h_full)
		else begin
			$error("f2h_write issued while f2h_full was high");
			fail_count++;
		end

endmodule

bind scara_link_top scara_link_assert assert_i (
	.CLOCK_50  (CLOCK_50),
	.arst_n    (arst_n),
	.h2f_read  (h2f_read),
	.f2h_write (f2h_write),
	.f2h_full  (f2h_full),
	.step1     (step1),
	.step2     (step2)
);

/* sim/scara_link_cases.txt */
// First value is the number of cases, then one case per line, all hex
// word stall_cycles fast steps1 dir1 steps2 dir2
0F
040C0051 00 0 05 0 03 1
06A80FF2 00 1 00 0 00 1
00201101 14 1 10 1 08 0
00001001 00 0 00 1 00 0
04300031 2D 0 03 0 0C 1
00000000 00 0 00 0 00 1
FFFC1FFF 08 1 00 0 00 1
04800201 00 1 20 0 20 1
F406E071 0F 0 07 0 01 1
12345673 03 0 00 0 01 1
07C00FF1 00 1 FF 0 F0 1
000010A1 1E 1 0A 1 00 0
A5A5A5A9 00 0 00 1 00 0
00080021 3C 0 02 0 02 0
047811E1 00 1 1E 1 1E 1

/* sim/scara_link_tb.sv */
// Testbench for the arm link top level with clock, reset, FIFO models, case reader and checks

`timescale 1ns/1ns

module scara_link_tb;

	// One count word first, then seven words per case
	localparam int MAX_CASES  = 32;
	localparam int CASE_WORDS = 7;
	localparam int WAIT_LIMIT = 20000;

	// Lit segments gfedcba for 0 to F, active high
	localparam logic [6:0] SEG_LIT [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	logic        CLOCK_50;
	logic        arst_n;
	logic [31:0] h2f_fill_level;
	logic [31:0] h2f_readdata;
	logic        f2h_full;
	logic        fast;
	logic        h2f_read;
	logic        f2h_write;
	logic [31:0] f2h_writedata;
	logic        step1, dir1, step2, dir2;
	logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;

	// FIFO models, host side pops and echo side records
	logic [31:0] host_q[$];
	logic [31:0] echo_q[$];
	logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS];
	int unsigned read_count, pulses1, pulses2;
	// Words the host claims on top of the modelled queue
	int unsigned extra_level;
	logic        step1_prev, step2_prev;
	int unsigned test_errors, total_errors, tests_run, tests_failed;
	logic        timed_out;
	// What the display should show
	logic [7:0]  disp1, disp2, cmd_total;

	scara_link_top dut_i (
		.CLOCK_50       (CLOCK_50),
		.arst_n         (arst_n),
		.h2f_fill_level (h2f_fill_level),
		.h2f_readdata   (h2f_readdata),
		.f2h_full       (f2h_full),
		.fast           (fast),
		.h2f_read       (h2f_read),
		.f2h_write      (f2h_write),
		.f2h_writedata  (f2h_writedata),
		.step1          (step1),
		.dir1           (dir1),
		.step2          (step2),
		.dir2           (dir2),
		.hex0           (hex0),
		.hex1           (hex1),
		.hex2           (hex2),
		.hex3           (hex3),
		.hex4           (hex4),
		.hex5           (hex5)
	);

	always #5 CLOCK_50 = ~CLOCK_50;

	// ========================================
	// Output monitors
	// ========================================

	// Echo capture and step edge counting on the rising edge
	always @(posedge CLOCK_50) begin
		if (f2h_write) begin
			echo_q.push_back(f2h_writedata);
		end
		if (step1 && !step1_prev) begin
			pulses1++;
		end
		if (step2 && !step2_prev) begin
			pulses2++;
		end
		step1_prev = step1;
		step2_prev = step2;
	end

	// Next falling edge, host FIFO pops on a read strobe
	task automatic tick();
		@(negedge CLOCK_50);
		if (h2f_read) begin
			read_count++;
			if (host_q.size() == 0) begin
				$display("Read strobe seen while the host FIFO model was empty");
				test_errors++;
			end else begin
				h2f_readdata = host_q.pop_front();
			end
		end
		h2f_fill_level = host_q.size() + extra_level;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("FAILED %s: expected %h, got %h", name, expected, got);
			test_errors++;
		end
	endtask

	// Active-low pattern for one digit
	function automatic logic [6:0] segments_for(input logic [3:0] digit);
		return ~SEG_LIT[digit];
	endfunction

	task automatic check_display();
		check_value("hex0", hex0, segments_for(disp1[3:0]));
		check_value("hex1", hex1, segments_for(disp1[7:4]));
		check_value("hex2", hex2, segments_for(disp2[3:0]));
		check_value("hex3", hex3, segments_for(disp2[7:4]));
		check_value("hex4", hex4, segments_for(cmd_total[3:0]));
		check_value("hex5", hex5, segments_for(cmd_total[7:4]));
	endtask

	task automatic finish_test(input int id);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("test %0d: ok", id);
		end else begin
			tests_failed++;
			$display("test %0d: %0d errors", id, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic wait_echo();
		int unsigned cycles;
		cycles = 0;
		while (echo_q.size() == 0 && cycles < WAIT_LIMIT) begin
			tick();
			cycles++;
		end
		if (echo_q.size() == 0) begin
			$display("Timeout: the echo write never appeared");
			timed_out = 1'b1;
		end
	endtask

	// Both joints parked and the echo machine back at rest
	task automatic wait_idle();
		int unsigned cycles;
		cycles = 0;
		while (!(dut_i.finished1 && dut_i.finished2 && !dut_i.echo_busy)
				&& cycles < WAIT_LIMIT) begin
			tick();
			cycles++;
		end
		if (cycles >= WAIT_LIMIT) begin
			$display("Timeout: the joints did not finish their move");
			timed_out = 1'b1;
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		int unsigned num_cases;
		int unsigned base;
		int unsigned stall;
		logic [31:0] word;
		logic        is_move;
		void'($urandom(32'hf682_7f46));
		CLOCK_50 = 1'b0;
		arst_n = 1'b0;
		h2f_fill_level = '0;
		h2f_readdata = '0;
		f2h_full = 1'b0;
		fast = 1'b0;
		read_count = 0;
		extra_level = 0;
		pulses1 = 0;
		pulses2 = 0;
		step1_prev = 1'b0;
		step2_prev = 1'b0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		disp1 = '0;
		disp2 = '0;
		cmd_total = '0;
		$readmemh("sim/scara_link_cases.txt", case_mem);
		num_cases = case_mem[0];
		repeat (4) tick();
		arst_n = 1'b1;

		// Quiet link with an empty host FIFO
		repeat (12) begin
			tick();
			check_value("h2f_read", h2f_read, 1'b0);
			check_value("f2h_write", f2h_write, 1'b0);
			check_value("step1", step1, 1'b0);
			check_value("step2", step2, 1'b0);
		end
		check_display();
		finish_test(0);

		assert (num_cases > 0 && num_cases <= MAX_CASES) else begin
			$display("Case file does not hold a usable case count");
			total_errors++;
			num_cases = 0;
		end

		for (int i = 0; i < num_cases && !timed_out; i++) begin
			base = 1 + i * CASE_WORDS;
			word = case_mem[base];
			stall = case_mem[base + 1];
			is_move = (word[3:0] == 4'h1);
			repeat ($urandom_range(4, 0)) tick();
			pulses1 = 0;
			pulses2 = 0;
			fast = case_mem[base + 2][0];
			f2h_full = (stall != 0);
			host_q.push_back(word);
			h2f_fill_level = host_q.size();
			// Echo must stay held while the outgoing FIFO is full
			// Host reports more words meanwhile, so an early read would show
			extra_level = (stall != 0);
			repeat (stall) begin
				tick();
				check_value("f2h_write", f2h_write, 1'b0);
				assert (read_count <= i + 1) else begin
					$display("A second read started while the echo was held");
					test_errors++;
				end
			end
			extra_level = 0;
			f2h_full = 1'b0;
			h2f_fill_level = host_q.size();
			wait_echo();
			check_value("read count", read_count, i + 1);
			if (!timed_out) begin
				wait_idle();
			end
			check_value("echo count", echo_q.size(), 1);
			check_value("f2h_writedata", echo_q[0], word);
			// Only move words step a joint
			check_value("step1 pulses", pulses1, is_move ? case_mem[base + 3] : 32'd0);
			check_value("dir1", dir1, case_mem[base + 4]);
			check_value("step2 pulses", pulses2, is_move ? case_mem[base + 5] : 32'd0);
			check_value("dir2", dir2, case_mem[base + 6]);
			// Non-move words leave the shown step counts alone
			cmd_total++;
			if (is_move) begin
				disp1 = case_mem[base + 3][7:0];
				disp2 = case_mem[base + 5][7:0];
			end
			check_display();
			echo_q.delete();
			finish_test(i + 1);
		end

		$display("%0d tests run, %0d failed, %0d assertion failures",
			tests_run, tests_failed, dut_i.assert_i.fail_count);
		if (total_errors == 0 && !timed_out && dut_i.assert_i.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* sources.f */
design/scara_link_pkg.sv
design/fifo_command_reader.sv
design/fifo_echo_writer.sv
design/stepper_joint.sv
design/hex_display.sv
design/scara_link_top.sv
sim/scara_link_assert.sv
sim/scara_link_tb.sv
